//--- sim.f
+incdir+include
src/acc_pkg.sv
src/word_ram.sv
src/acc_alu.sv
src/acc_core.sv
src/host_regs.sv
src/acc_machine_top.sv
bench/axil_host.sv
bench/tb_acc_machine.sv

//--- Bender.yml
package:
  name: acc_machine

export_include_dirs:
  - include

sources:
  - src/acc_pkg.sv
  - src/word_ram.sv
  - src/acc_alu.sv
  - src/acc_core.sv
  - src/host_regs.sv
  - src/acc_machine_top.sv
  - target: test
    files:
      - bench/axil_host.sv
      - bench/tb_acc_machine.sv

//--- bench/tb_acc_machine.sv
`default_nettype none

`include "acc_config.svh"

// Random programs through the host port, checked against an instruction-set model
module tb_acc_machine
    import acc_pkg::*;
;

    localparam int CLK_PERIOD    = 8;
    localparam int NUM_PROGS     = 10;
    localparam int MAX_INSTR     = 48;
    localparam int HOST_READS    = 40;
    localparam int WATCHDOG_TIME = NUM_PROGS * (MAX_INSTR + MAX_INSTR * 4 + HOST_READS)
                                   * CLK_PERIOD * 4;
    localparam logic [11:0] CTRL_ADDR = 12'h000;
    localparam logic [11:0] ACC_ADDR  = 12'h004;
    localparam logic [11:0] PC_ADDR   = 12'h008;
    localparam logic [11:0] PROG_BASE = 12'h400;
    localparam logic [11:0] DATA_BASE = 12'h800;
    localparam logic [1:0]  OKAY      = 2'b00;
    localparam logic [1:0]  SLVERR    = 2'b10;

    logic        clock;
    logic        reset;
    logic [11:0] s_axil_awaddr;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic [3:0]  s_axil_wstrb;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    logic [11:0] s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;

    integer      seed = 32'had27_4d10;
    int          error_count = 0;
    logic [15:0] program_words [256]; // Image of what was loaded
    word_t       model_mem [16];       // Data words 0..15 as the model sees them
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          len;

    acc_machine_top dut0 (.*);

    axil_host host0 (
        .clock   (clock),
        .awaddr  (s_axil_awaddr),
        .awvalid (s_axil_awvalid),
        .awready (s_axil_awready),
        .wdata   (s_axil_wdata),
        .wstrb   (s_axil_wstrb),
        .wvalid  (s_axil_wvalid),
        .wready  (s_axil_wready),
        .bresp   (s_axil_bresp),
        .bvalid  (s_axil_bvalid),
        .bready  (s_axil_bready),
        .araddr  (s_axil_araddr),
        .arvalid (s_axil_arvalid),
        .arready (s_axil_arready),
        .rdata   (s_axil_rdata),
        .rresp   (s_axil_rresp),
        .rvalid  (s_axil_rvalid),
        .rready  (s_axil_rready)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic int rand_below(input int n);
        rand_below = int'($unsigned($random(seed)) % n);
    endfunction

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // LDI 0 then STORE to every data word the tests use
    task automatic build_clear_program(output int n);
        program_words[0] = {LDI, 12'h000};
        for (int i = 0; i < 16; i++) begin
            program_words[1 + i] = {STORE, 12'(i)};
        end
        program_words[17] = {HALT, 12'h000};
        n = 18;
    endtask

    task automatic build_random_program(input bit allow_jump, input int n);
        int          r;
        opcode_e     op;
        logic [11:0] operand;
        for (int i = 0; i < n - 1; i++) begin
            r = rand_below(allow_jump ? 15 : 14);
            case (r)
                12:      op = SKZ;
                13:      op = SKN;
                14:      op = JUMP;
                default: op = opcode_e'(4'(r + 1)); // LDI through ROR
            endcase
            if ((op == SKZ || op == SKN) && i > n - 3) begin
                op = LDI; // Skip must not jump past HALT
            end
            case (op)
                LOAD, STORE, ADD, SUB, AND, OR, XOR:
                    operand = {4'(rand_below(16)), 4'h0, 4'(rand_below(16))}; // High junk
                JUMP:
                    operand = {4'(rand_below(16)), 8'(i + 1 + rand_below(n - 1 - i))};
                default:
                    operand = 12'(rand_below(4096));
            endcase
            program_words[i] = {op, operand};
        end
        program_words[n - 1] = {HALT, 12'(rand_below(4096))};
    endtask

    // Reference execution straight from the opcode table
    task automatic run_model(output word_t exp_acc, output logic [7:0] exp_pc);
        logic [7:0]  pc;
        logic [7:0]  next_pc;
        word_t       acc;
        logic [11:0] opr;
        opcode_e     op;
        bit          done;
        int          steps;
        pc    = 8'h00;
        acc   = 16'h0000;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 256) begin
            op      = opcode_e'(program_words[pc][15:12]);
            opr     = program_words[pc][11:0];
            next_pc = pc + 8'd1; // Wraps at 256
            steps++;
            case (op)
                HALT:  done = 1'b1;
                LDI:   acc = {4'h0, opr};
                LOAD:  acc = model_mem[opr[3:0]];
                STORE: model_mem[opr[3:0]] = acc;
                ADD:   acc = acc + model_mem[opr[3:0]];
                SUB:   acc = acc - model_mem[opr[3:0]];
                AND:   acc = acc & model_mem[opr[3:0]];
                OR:    acc = acc | model_mem[opr[3:0]];
                XOR:   acc = acc ^ model_mem[opr[3:0]];
                SHL:   acc = {acc[14:0], 1'b0};
                SHR:   acc = {1'b0, acc[15:1]};
                ROL:   acc = {acc[14:0], acc[15]};
                ROR:   acc = {acc[0], acc[15:1]};
                JUMP:  next_pc = opr[7:0];
                SKZ:   if (acc == 16'h0000) next_pc = pc + 8'd2;
                SKN:   if (acc[15]) next_pc = pc + 8'd2;
            endcase
            pc = next_pc;
        end
        if (!done) begin
            $display("model did not reach HALT within 256 steps");
            error_count++;
        end
        exp_acc = acc;
        exp_pc  = pc; // Halting address plus one
    endtask

    task automatic load_program(input int n, input string name);
        logic [31:0] rd;
        logic [1:0]  rsp;
        for (int i = 0; i < n; i++) begin
            host0.axil_write(PROG_BASE + 12'(4 * i), {16'h0, program_words[i]}, rsp);
            compare_word($sformatf("%s load resp %0d", name, i), OKAY, rsp);
        end
        for (int i = 0; i < n; i++) begin
            host0.axil_read(PROG_BASE + 12'(4 * i), rd, rsp);
            compare_word($sformatf("%s readback %0d", name, i), {16'h0, program_words[i]}, rd);
            compare_word($sformatf("%s readback resp %0d", name, i), OKAY, rsp);
        end
    endtask

    task automatic run_and_check(input string name, input bit probe_busy);
        logic [31:0] rd;
        logic [1:0]  rsp;
        word_t       exp_acc;
        logic [7:0]  exp_pc;
        run_model(exp_acc, exp_pc);
        host0.axil_write(CTRL_ADDR, 32'h1, rsp);
        compare_word({name, " start resp"}, OKAY, rsp);
        if (probe_busy) begin
            host0.axil_read(CTRL_ADDR, rd, rsp);
            compare_word({name, " busy status"}, 32'h1, rd);
            host0.axil_write(PROG_BASE, {16'h0, ~program_words[0]}, rsp); // Must be refused
            compare_word({name, " prog write while busy"}, SLVERR, rsp);
            host0.axil_write(CTRL_ADDR, 32'h1, rsp);
            compare_word({name, " start while busy"}, SLVERR, rsp);
        end
        do host0.axil_read(CTRL_ADDR, rd, rsp); while (rd[1] !== 1'b1); // Poll halted
        compare_word({name, " final status"}, 32'h2, rd);
        host0.axil_read(ACC_ADDR, rd, rsp);
        compare_word({name, " acc"}, {16'h0, exp_acc}, rd);
        host0.axil_read(PC_ADDR, rd, rsp);
        compare_word({name, " pc"}, {24'h0, exp_pc}, rd);
        for (int i = 0; i < 16; i++) begin
            host0.axil_read(DATA_BASE + 12'(4 * i), rd, rsp);
            compare_word($sformatf("%s data %0d", name, i), {16'h0, model_mem[i]}, rd);
        end
        if (probe_busy) begin
            host0.axil_read(PROG_BASE, rd, rsp);
            compare_word({name, " prog word 0 kept"}, {16'h0, program_words[0]}, rd);
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units, run did not finish", WATCHDOG_TIME);
        $display("errors: %0d", error_count);
        $display("sim failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        for (int i = 0; i < 16; i++) begin
            model_mem[i] = 16'h0000;
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        host0.axil_read(CTRL_ADDR, rdata, resp);
        compare_word("reset status", 32'h0, rdata);
        compare_word("reset status resp", OKAY, resp);
        host0.axil_read(12'h00C, rdata, resp); // Hole in register space
        compare_word("unmapped read data", 32'h0, rdata);
        compare_word("unmapped read resp", SLVERR, resp);
        host0.axil_read(12'hC00, rdata, resp); // Top quarter is unmapped
        compare_word("unmapped region data", 32'h0, rdata);
        compare_word("unmapped region resp", SLVERR, resp);
        host0.axil_write(12'h010, 32'h1234, resp);
        compare_word("unmapped write resp", SLVERR, resp);
        host0.axil_write(ACC_ADDR, 32'h1, resp);
        compare_word("acc write resp", SLVERR, resp);
        host0.axil_write(DATA_BASE, 32'h55, resp);
        compare_word("data window write resp", SLVERR, resp);
        build_clear_program(len);
        load_program(len, "clear");
        run_and_check("clear", 1'b0);
        for (int p = 1; p < NUM_PROGS - 1; p++) begin
            len = 8 + rand_below(MAX_INSTR - 7); // 8 to 48 instructions
            build_random_program(1'b1, len);
            load_program(len, $sformatf("prog%0d", p));
            run_and_check($sformatf("prog%0d", p), 1'b0);
        end
        build_random_program(1'b0, MAX_INSTR); // Long and jump-free, stays busy
        load_program(MAX_INSTR, "busy");
        run_and_check("busy", 1'b1);
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/axil_host.sv
`default_nettype none

`include "acc_config.svh"

// AXI4-Lite master for the testbench, one transaction at a time
module axil_host (
    input  wire                          clock,
    output logic [`ACC_AXI_ADDR_BITS-1:0] awaddr,
    output logic                         awvalid,
    input  wire                          awready,
    output logic [31:0]                  wdata,
    output logic [3:0]                   wstrb,
    output logic                         wvalid,
    input  wire                          wready,
    input  wire  [1:0]                   bresp,
    input  wire                          bvalid,
    output logic                         bready,
    output logic [`ACC_AXI_ADDR_BITS-1:0] araddr,
    output logic                         arvalid,
    input  wire                          arready,
    input  wire  [31:0]                  rdata,
    input  wire  [1:0]                   rresp,
    input  wire                          rvalid,
    output logic                         rready
);

    initial begin
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0; // Raised only once a response is seen
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
    end

    // Address and data go out together, slave pulses both readies
    task automatic axil_write(input logic [`ACC_AXI_ADDR_BITS-1:0] addr,
                              input logic [31:0] data, output logic [1:0] resp);
        @(posedge clock);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF; // Full word
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(negedge clock); while (!(awready && wready)); // Sample mid-cycle
        @(posedge clock); // Handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(negedge clock); while (!bvalid);
        resp = bresp;
        @(posedge clock);
        bready <= 1'b1; // Response waits one cycle first
        @(posedge clock);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [`ACC_AXI_ADDR_BITS-1:0] addr,
                             output logic [31:0] data, output logic [1:0] resp);
        @(posedge clock);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(negedge clock); while (!arready);
        @(posedge clock);
        arvalid <= 1'b0;
        do @(negedge clock); while (!rvalid); // One or two cycles later
        data = rdata;
        resp = rresp;
        @(posedge clock);
        rready <= 1'b1; // Read data held a cycle by the slave
        @(posedge clock);
        rready <= 1'b0;
    endtask

endmodule

`default_nettype wire

//--- src/acc_machine_top.sv
`default_nettype none

`include "acc_config.svh"

// Host block, core, program memory and data memory
module acc_machine_top
    import acc_pkg::*;
(
    input  wire                          clock,
    input  wire                          reset,
    input  wire [`ACC_AXI_ADDR_BITS-1:0] s_axil_awaddr,
    input  wire                          s_axil_awvalid,
    output logic                         s_axil_awready,
    input  wire [31:0]                   s_axil_wdata,
    input  wire [3:0]                    s_axil_wstrb,
    input  wire                          s_axil_wvalid,
    output logic                         s_axil_wready,
    output logic [1:0]                   s_axil_bresp,
    output logic                         s_axil_bvalid,
    input  wire                          s_axil_bready,
    input  wire [`ACC_AXI_ADDR_BITS-1:0] s_axil_araddr,
    input  wire                          s_axil_arvalid,
    output logic                         s_axil_arready,
    output logic [31:0]                  s_axil_rdata,
    output logic [1:0]                   s_axil_rresp,
    output logic                         s_axil_rvalid,
    input  wire                          s_axil_rready
);

    logic      start;
    logic      busy;
    logic      halted;
    word_t     acc;
    mem_addr_t pc;
    logic      prog_we;      // Host is the only program writer
    mem_addr_t prog_waddr;
    instr_t    prog_wdata;
    mem_addr_t prog_raddr;   // Host side reads
    instr_t    prog_rdata;
    mem_addr_t data_raddr;
    word_t     data_rdata;
    mem_addr_t prog_addr;    // Core side
    instr_t    prog_data;
    mem_addr_t data_addr;
    word_t     data_core_rdata;
    logic      data_we;      // Core is the only data writer
    word_t     data_wdata;

    host_regs u_host (
        .clock          (clock),
        .reset          (reset),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .start          (start),
        .busy           (busy),
        .halted         (halted),
        .acc            (acc),
        .pc             (pc),
        .prog_we        (prog_we),
        .prog_waddr     (prog_waddr),
        .prog_wdata     (prog_wdata),
        .prog_raddr     (prog_raddr),
        .prog_rdata     (prog_rdata),
        .data_raddr     (data_raddr),
        .data_rdata     (data_rdata)
    );

    acc_core u_core (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .busy       (busy),
        .halted     (halted),
        .acc        (acc),
        .pc         (pc),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .data_addr  (data_addr),
        .data_rdata (data_core_rdata),
        .data_we    (data_we),
        .data_wdata (data_wdata)
    );

    word_ram #(.payload_t(instr_t)) u_prog_mem (
        .clock   (clock),
        .we      (prog_we),
        .waddr   (prog_waddr),
        .wdata   (prog_wdata),
        .raddr_a (prog_raddr),
        .rdata_a (prog_rdata),
        .raddr_b (prog_addr),
        .rdata_b (prog_data)
    );

    word_ram #(.payload_t(word_t)) u_data_mem (
        .clock   (clock),
        .we      (data_we),
        .waddr   (data_addr),  // Read and write share the core address
        .wdata   (data_wdata),
        .raddr_a (data_raddr),
        .rdata_a (data_rdata),
        .raddr_b (data_addr),
        .rdata_b (data_core_rdata)
    );

endmodule

`default_nettype wire

//--- src/host_regs.sv
`default_nettype none

`include "acc_config.svh"

// AXI4-Lite slave
// 0x000 CTRL  wr bit0 start, rd bit0 busy bit1 halted
// 0x004 ACC   read only
// 0x008 PC    read only
// 0x400-0x7FC program memory, write only while idle
// 0x800-0xBFC data memory, read only
module host_regs
    import acc_pkg::*;
(
    input  wire                          clock,
    input  wire                          reset,
    input  wire [`ACC_AXI_ADDR_BITS-1:0] s_axil_awaddr,
    input  wire                          s_axil_awvalid,
    output logic                         s_axil_awready,
    input  wire [31:0]                   s_axil_wdata,
    input  wire [3:0]                    s_axil_wstrb,
    input  wire                          s_axil_wvalid,
    output logic                         s_axil_wready,
    output logic [1:0]                   s_axil_bresp,
    output logic                         s_axil_bvalid,
    input  wire                          s_axil_bready,
    input  wire [`ACC_AXI_ADDR_BITS-1:0] s_axil_araddr,
    input  wire                          s_axil_arvalid,
    output logic                         s_axil_arready,
    output logic [31:0]                  s_axil_rdata,
    output logic [1:0]                   s_axil_rresp,
    output logic                         s_axil_rvalid,
    input  wire                          s_axil_rready,
    output logic                         start,
    input  wire                          busy,
    input  wire                          halted,
    input  wire word_t                   acc,
    input  wire mem_addr_t               pc,
    output logic                         prog_we,
    output mem_addr_t                    prog_waddr,
    output instr_t                       prog_wdata,
    output mem_addr_t                    prog_raddr,
    input  wire instr_t                  prog_rdata,
    output mem_addr_t                    data_raddr,
    input  wire word_t                   data_rdata
);

    localparam int                          AW       = `ACC_AXI_ADDR_BITS;
    localparam logic [AW-1:0]               CTRL_ADDR = 'h000;
    localparam logic [AW-1:0]               ACC_ADDR  = 'h004;
    localparam logic [AW-1:0]               PC_ADDR   = 'h008;
    localparam logic [1:0]                  RGN_PROG  = 2'b01; // Top two address bits
    localparam logic [1:0]                  RGN_DATA  = 2'b10;
    localparam logic [1:0]                  RESP_OKAY = 2'b00;
    localparam logic [1:0]                  RESP_SLV  = 2'b10;

    logic [AW-1:0] rd_addr;     // Held from acceptance until data returns
    logic          rd_mem_wait; // Memory read in flight
    logic          idle;
    logic          wr_fire;
    logic          rd_fire;
    logic          rd_is_mem;
    logic          prog_ok;
    logic          ctrl_ok;
    logic          reg_hit;
    logic [31:0]   reg_rdata;
    logic [31:0]   mem_rdata;

    assign idle    = !s_axil_awready && !s_axil_arready && !s_axil_bvalid
                     && !s_axil_rvalid && !rd_mem_wait; // One transaction at a time
    assign wr_fire = s_axil_awready && s_axil_awvalid && s_axil_wvalid;
    assign rd_fire = s_axil_arready && s_axil_arvalid;

    // Write decode, full 16-bit lane needed for an instruction
    assign prog_ok = (s_axil_awaddr[AW-1 -: 2] == RGN_PROG) && !busy && (&s_axil_wstrb[1:0]);
    assign ctrl_ok = (s_axil_awaddr == CTRL_ADDR)
                     && !(s_axil_wstrb[0] && s_axil_wdata[0] && busy);

    assign prog_we    = wr_fire && prog_ok;
    assign prog_waddr = s_axil_awaddr[2 +: $bits(mem_addr_t)];
    assign prog_wdata = instr_t'(s_axil_wdata[15:0]);
    assign start      = wr_fire && ctrl_ok && s_axil_wstrb[0] && s_axil_wdata[0];

    assign prog_raddr = rd_addr[2 +: $bits(mem_addr_t)]; // Both windows share the index
    assign data_raddr = rd_addr[2 +: $bits(mem_addr_t)];
    assign rd_is_mem  = (rd_addr[AW-1 -: 2] == RGN_PROG) || (rd_addr[AW-1 -: 2] == RGN_DATA);
    assign mem_rdata  = (rd_addr[AW-1 -: 2] == RGN_PROG) ? {16'b0, prog_rdata}
                                                         : {16'b0, data_rdata};

    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (rd_addr)
            CTRL_ADDR: reg_rdata = {30'b0, halted, busy};
            ACC_ADDR:  reg_rdata = {16'b0, acc};
            PC_ADDR:   reg_rdata = {24'b0, pc};
            default:   reg_hit   = 1'b0; // Unmapped, zero data
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            rd_mem_wait    <= 1'b0;
        end else begin
            s_axil_awready <= 1'b0; // Ready lines are single pulses
            s_axil_wready  <= 1'b0;
            s_axil_arready <= 1'b0;
            if (idle && s_axil_arvalid) begin // Read first on a tie
                s_axil_arready <= 1'b1;
            end else if (idle && s_axil_awvalid && s_axil_wvalid) begin
                s_axil_awready <= 1'b1;
                s_axil_wready  <= 1'b1;
            end
            if (wr_fire) begin
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
            rd_mem_wait <= rd_fire && rd_is_mem; // Extra cycle for RAM output
            if ((rd_fire && !rd_is_mem) || rd_mem_wait) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (idle && s_axil_arvalid) begin
            rd_addr <= s_axil_araddr;
        end
        if (wr_fire) begin
            s_axil_bresp <= (prog_ok || ctrl_ok) ? RESP_OKAY : RESP_SLV;
        end
        if (rd_fire && !rd_is_mem) begin
            s_axil_rdata <= reg_rdata;
            s_axil_rresp <= reg_hit ? RESP_OKAY : RESP_SLV;
        end else if (rd_mem_wait) begin
            s_axil_rdata <= mem_rdata;
            s_axil_rresp <= RESP_OKAY;
        end
    end

    // Responses stay up and steady until the master takes them
    a_bvalid_hold: assert property (@(posedge clock) disable iff (reset)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
        else $error("BVALID or BRESP changed before BREADY");

    a_rvalid_hold: assert property (@(posedge clock) disable iff (reset)
        s_axil_rvalid && !s_axil_rready
        |=> s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp))
        else $error("RVALID or read data changed before RREADY");

endmodule

`default_nettype wire

//--- src/acc_core.sv
`default_nettype none

// Four-cycle accumulator sequencer: fetch, decode, memory, execute
module acc_core
    import acc_pkg::*;
(
    input  wire            clock,
    input  wire            reset,
    input  wire            start,      // One-cycle pulse from host block
    output logic           busy,
    output logic           halted,
    output word_t          acc,
    output mem_addr_t      pc,
    output mem_addr_t      prog_addr,
    input  wire instr_t    prog_data,
    output mem_addr_t      data_addr,
    input  wire word_t     data_rdata,
    output logic           data_we,
    output word_t          data_wdata
);

    core_state_e state;
    instr_t      ir;          // Latched instruction
    word_t       alu_operand;
    word_t       alu_result;
    logic        take_skip;

    assign prog_addr  = pc; // Presented in FETCH, word arrives in DECODE
    assign data_addr  = ir.operand[$bits(mem_addr_t)-1:0]; // Valid from MEMORY on
    assign data_wdata = acc;
    assign data_we    = (state == EXECUTE) && (ir.opcode == STORE);

    // LDI takes the immediate, everything else the data word read in MEMORY
    assign alu_operand = (ir.opcode == LDI) ? word_t'(ir.operand) : data_rdata;

    acc_alu u_alu (
        .op        (ir.opcode),
        .acc       (acc),
        .operand   (alu_operand),
        .result    (alu_result),
        .take_skip (take_skip)
    );

    // Instruction register, loaded once per instruction
    always_ff @(posedge clock) begin
        if (state == DECODE) begin
            ir <= prog_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state  <= IDLE;
            busy   <= 1'b0;
            halted <= 1'b0;
            pc     <= '0;
            acc    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin // New run from address zero
                        state  <= FETCH;
                        busy   <= 1'b1;
                        halted <= 1'b0;
                        pc     <= '0;
                        acc    <= '0;
                    end
                end
                FETCH:  state <= DECODE;
                DECODE: state <= MEMORY;
                MEMORY: state <= EXECUTE; // Data read in flight
                EXECUTE: begin
                    acc   <= alu_result; // Unchanged for non-acc ops
                    state <= FETCH;
                    case (ir.opcode)
                        HALT: begin
                            pc     <= pc + mem_addr_t'(1); // Halting address plus one
                            busy   <= 1'b0;
                            halted <= 1'b1;
                            state  <= IDLE;
                        end
                        JUMP:     pc <= ir.operand[$bits(mem_addr_t)-1:0];
                        SKZ, SKN: pc <= pc + (take_skip ? mem_addr_t'(2) : mem_addr_t'(1));
                        default:  pc <= pc + mem_addr_t'(1); // Wraps at 256
                    endcase
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Stores land only in the execute slot of a live run, right after MEMORY
    a_store_in_execute: assert property (@(posedge clock) disable iff (reset)
        data_we |-> busy && $past(state) == MEMORY)
        else $error("data write outside EXECUTE");

    // Host block must refuse a start while a program runs
    a_no_start_busy: assert property (@(posedge clock) disable iff (reset)
        start |-> !busy)
        else $error("start pulse while busy");

    a_idle_when_free: assert property (@(posedge clock) disable iff (reset)
        !busy |-> state == IDLE)
        else $error("core sequencing while not busy");

endmodule

`default_nettype wire

//--- src/acc_alu.sv
`default_nettype none

// Execute unit of the core, purely combinational
module acc_alu
    import acc_pkg::*;
(
    input  wire opcode_e op,
    input  wire word_t   acc,
    input  wire word_t   operand,   // Memory word or immediate
    output word_t        result,    // Next acc value
    output logic         take_skip
);

    localparam int W = $bits(word_t);

    always_comb begin
        result = acc; // Hold acc by default
        case (op)
            LDI,
            LOAD:    result = operand;
            ADD:     result = acc + operand;
            SUB:     result = acc - operand;
            AND:     result = acc & operand;
            OR:      result = acc | operand;
            XOR:     result = acc ^ operand;
            SHL:     result = acc << 1;
            SHR:     result = acc >> 1; // Logical, zero fill
            ROL:     result = {acc[W-2:0], acc[W-1]};
            ROR:     result = {acc[0], acc[W-1:1]};
            default: result = acc; // HALT, STORE, JUMP, skips
        endcase
    end

    // Skip decision only meaningful for the two skip opcodes
    always_comb begin
        case (op)
            SKZ:     take_skip = (acc == '0);
            SKN:     take_skip = acc[W-1];
            default: take_skip = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/word_ram.sv
`default_nettype none

`include "acc_config.svh"

// Word-wide RAM, one write port, two registered read ports
module word_ram
    import acc_pkg::*;
#(
    parameter type payload_t = word_t,
    parameter int  DEPTH     = `ACC_MEM_WORDS
) (
    input  wire            clock,
    input  wire            we,
    input  wire mem_addr_t waddr,
    input  wire payload_t  wdata,
    input  wire mem_addr_t raddr_a,
    output payload_t       rdata_a,
    input  wire mem_addr_t raddr_b,
    output payload_t       rdata_b
);

    payload_t mem [DEPTH]; // Storage array

    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata; // Write wins over nothing, ports are independent
        end
        rdata_a <= mem[raddr_a]; // Data one cycle after address
        rdata_b <= mem[raddr_b];
    end

    // A write with an unknown address would corrupt the whole array in simulation
    a_waddr_known: assert property (@(posedge clock) we |-> !$isunknown(waddr))
        else $error("word_ram write with unknown address");

endmodule

`default_nettype wire

//--- src/acc_pkg.sv
`default_nettype none

`include "acc_config.svh"

package acc_pkg;

    typedef logic [`ACC_WORD_BITS-1:0] word_t; // Acc and data memory word
    typedef logic [$clog2(`ACC_MEM_WORDS)-1:0] mem_addr_t; // Word address into either memory

    typedef enum logic [3:0] {
        HALT  = 4'h0,
        LDI   = 4'h1, // Zero-extended immediate
        LOAD  = 4'h2,
        STORE = 4'h3,
        ADD   = 4'h4,
        SUB   = 4'h5,
        AND   = 4'h6,
        OR    = 4'h7,
        XOR   = 4'h8,
        SHL   = 4'h9, // Single-bit shifts and rotates
        SHR   = 4'hA,
        ROL   = 4'hB,
        ROR   = 4'hC,
        JUMP  = 4'hD,
        SKZ   = 4'hE, // Skip next if acc is zero
        SKN   = 4'hF  // Skip next if acc is negative
    } opcode_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] operand; // Memory ops use the low address bits only
    } instr_t;

    typedef enum logic [2:0] {IDLE, FETCH, DECODE, MEMORY, EXECUTE} core_state_e;

endpackage

`default_nettype wire

//--- include/acc_config.svh
`ifndef ACC_CONFIG_SVH
`define ACC_CONFIG_SVH

// Accumulator, data memory word and instruction word are all this wide
`define ACC_WORD_BITS 16

// Program and data memory have the same depth
`define ACC_MEM_WORDS 256

// Host port byte address
`define ACC_AXI_ADDR_BITS 12

`endif
